//--- list.f
logic/dbg_chain_pkg.sv
logic/dbg_bus_pkg.sv
logic/dbg_bus_module.sv
logic/dbg_cpu_module.sv
logic/dbg_hub_top.sv
testbench/dbg_hub_tb.sv

//--- logic/dbg_bus_module.sv
`timescale 1ns/1ps

module dbg_bus_module
  import dbg_chain_pkg::*;
  import dbg_bus_pkg::*;
(
  input  logic                    tck_i,
  input  logic                    tlr_i,
  input  dbg_tap_t                tap_i,
  input  dbg_word_u               chain_word_i,
  input  logic                    select_i,
  output logic                    module_tdo_o,
  output logic                    bus_inhibit_o,
  // Strobe/ack bus
  output bus_req_t                bus_req_o,
  input  logic [BUS_DATA_LEN-1:0] bus_rdata_i,
  input  logic                    bus_ack_i
);

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  dbg_cmd_t cmd;
  logic     is_bus_op;
  logic     start_access;
  logic     ack_seen;

  // Access state
  logic                          stb_q;
  logic                          done_q;
  logic [BUS_DATA_LEN-1:0]       rdata_q;
  logic                          we_q;
  logic [BUS_ADDR_LEN-1:0]       addr_q;
  logic [BUS_DATA_LEN-1:0]       wdata_q;
  logic [BUS_RESULT_LEN-1:0]     result_q;

  assign cmd = chain_word_i.cmd;

  // Only the two bus opcodes belong here
  assign is_bus_op = (cmd.opcode == OP_BUS_WRITE) || (cmd.opcode == OP_BUS_READ);

  // Accepted on Update-DR unless an access is still open
  assign start_access = tap_i.update_dr && select_i && !cmd.select_cmd &&
                        is_bus_op && !stb_q;

  // Access ends on first edge with strobe and ack
  assign ack_seen = stb_q && bus_ack_i;

  ////////////////////////////////////////
  // Access state
  ////////////////////////////////////////

  // Strobe and done flag
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stb_q  <= 1'b0;
      done_q <= 1'b0;
    end else if (start_access) begin
      stb_q  <= 1'b1;
      done_q <= 1'b0;
    end else if (ack_seen) begin
      stb_q  <= 1'b0;
      done_q <= 1'b1;
    end
  end

  // Read data kept until the next read completes
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rdata_q <= '0;
    end else if (ack_seen && !we_q) begin
      rdata_q <= bus_rdata_i;
    end
  end

  // Request payload, stable for the whole strobe
  always_ff @(posedge tck_i) begin
    if (start_access) begin
      we_q    <= (cmd.opcode == OP_BUS_WRITE);
      addr_q  <= cmd.addr;
      wdata_q <= cmd.data;
    end
  end

  assign bus_req_o = '{
    stb:   stb_q,
    we:    we_q,
    addr:  addr_q,
    wdata: wdata_q
  };

  // Blocks new selects while pending
  assign bus_inhibit_o = stb_q;

  ////////////////////////////////////////
  // Result shift-out
  ////////////////////////////////////////

  // Done in bit 0 and read data above it
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      result_q <= '0;
    end else if (select_i && tap_i.capture_dr) begin
      result_q <= {rdata_q, done_q};
    end else if (select_i && tap_i.shift_dr) begin
      result_q <= {tap_i.tdi, result_q[BUS_RESULT_LEN-1:1]};
    end
  end

  assign module_tdo_o = result_q[0];

endmodule

//--- logic/dbg_bus_pkg.sv
package dbg_bus_pkg;

  ////////////////////////////////////////
  // Strobe/ack bus
  ////////////////////////////////////////

  localparam int BUS_ADDR_LEN = 8;
  localparam int BUS_DATA_LEN = 32;

  // Done flag in bit 0 then read data
  localparam int BUS_RESULT_LEN = 1 + BUS_DATA_LEN;

  // Request lines towards the bus
  typedef struct packed {
    logic                    stb;
    logic                    we;
    logic [BUS_ADDR_LEN-1:0] addr;
    logic [BUS_DATA_LEN-1:0] wdata;
  } bus_req_t;

  ////////////////////////////////////////
  // CPU status word
  ////////////////////////////////////////

  // Stall field in low half, breakpoints in high half
  localparam int CPU_FIELD_LEN  = 16;
  localparam int CPU_STATUS_LEN = 2 * CPU_FIELD_LEN;

endpackage

//--- logic/dbg_chain_pkg.sv
package dbg_chain_pkg;

  ////////////////////////////////////////
  // Main chain geometry
  ////////////////////////////////////////

  localparam int DATAREG_LEN   = 44;
  localparam int MODULE_ID_LEN = 2;
  // One select line per possible ID
  localparam int MODULE_COUNT  = 2 ** MODULE_ID_LEN;

  // Module IDs carried by a select word
  localparam logic [MODULE_ID_LEN-1:0] MODULE_BUS        = 2'd0;
  localparam logic [MODULE_ID_LEN-1:0] MODULE_CPU        = 2'd1;
  localparam logic [MODULE_ID_LEN-1:0] MODULE_RESERVED_A = 2'd2;
  localparam logic [MODULE_ID_LEN-1:0] MODULE_RESERVED_B = 2'd3;

  // Opcodes of a module command word
  typedef enum logic [2:0] {
    OP_NOP           = 3'd0,
    OP_BUS_WRITE     = 3'd1,
    OP_BUS_READ      = 3'd2,
    OP_CPU_STALL_SET = 3'd3,
    OP_CPU_STATUS    = 3'd4
  } dbg_opcode_e;

  // TAP strobes as seen by each debug module
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdi;
  } dbg_tap_t;

  // Select view of the chain word
  typedef struct packed {
    logic                                 select_cmd;
    logic [MODULE_ID_LEN-1:0]             module_id;
    logic [DATAREG_LEN-MODULE_ID_LEN-2:0] unused;
  } dbg_select_t;

  // Command view of the chain word
  typedef struct packed {
    logic        select_cmd;
    dbg_opcode_e opcode;
    logic [7:0]  addr;
    logic [31:0] data;
  } dbg_cmd_t;

  // Same 44 bits, two decodings
  typedef union packed {
    dbg_select_t sel;
    dbg_cmd_t    cmd;
  } dbg_word_u;

endpackage

//--- logic/dbg_cpu_module.sv
`timescale 1ns/1ps

module dbg_cpu_module
  import dbg_chain_pkg::*;
  import dbg_bus_pkg::*;
#(
  parameter int CORE_COUNT = 2
) (
  input  logic                  tck_i,
  input  logic                  tlr_i,
  input  dbg_tap_t              tap_i,
  input  dbg_word_u             chain_word_i,
  input  logic                  select_i,
  output logic                  module_tdo_o,
  // Per-core control
  output logic [CORE_COUNT-1:0] core_stall_o,
  input  logic [CORE_COUNT-1:0] core_bp_i
);

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  dbg_cmd_t cmd;
  logic     stall_write;

  assign cmd = chain_word_i.cmd;

  // Status read has no side effect
  // so only the stall write is decoded
  assign stall_write = tap_i.update_dr && select_i && !cmd.select_cmd &&
                       (cmd.opcode == OP_CPU_STALL_SET);

  ////////////////////////////////////////
  // Stall register
  ////////////////////////////////////////

  logic [CORE_COUNT-1:0] stall_q;
  logic [CORE_COUNT-1:0] stall_base;

  // Write replaces the mask, otherwise hold
  assign stall_base = stall_write ? cmd.data[CORE_COUNT-1:0] : stall_q;

  // Breakpoints always win
  // a write of 0 cannot clear a core still at its breakpoint
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stall_q <= '0;
    end else begin
      stall_q <= stall_base | core_bp_i;
    end
  end

  assign core_stall_o = stall_q;

  ////////////////////////////////////////
  // Status shift-out
  ////////////////////////////////////////

  logic [CPU_STATUS_LEN-1:0] status;
  logic [CPU_STATUS_LEN-1:0] result_q;

  // Stall in low field, breakpoints in high field
  always_comb begin
    status                                = '0;
    status[CORE_COUNT-1:0]                = stall_q;
    status[CPU_FIELD_LEN +: CORE_COUNT]   = core_bp_i;
  end

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      result_q <= '0;
    end else if (select_i && tap_i.capture_dr) begin
      result_q <= status;
    end else if (select_i && tap_i.shift_dr) begin
      result_q <= {tap_i.tdi, result_q[CPU_STATUS_LEN-1:1]};
    end
  end

  // LSB leads on TDO
  assign module_tdo_o = result_q[0];

endmodule

//--- logic/dbg_hub_top.sv
`timescale 1ns/1ps

module dbg_hub_top
  import dbg_chain_pkg::*;
  import dbg_bus_pkg::*;
#(
  parameter int CORE_COUNT = 2
) (
  input  logic                    tck_i,
  input  logic                    tlr_i,
  input  logic                    tdi_i,
  input  logic                    shift_dr_i,
  input  logic                    capture_dr_i,
  input  logic                    update_dr_i,
  input  logic                    debug_select_i,
  output logic                    tdo_o,
  // Bus master side
  output bus_req_t                bus_req_o,
  input  logic [BUS_DATA_LEN-1:0] bus_rdata_i,
  input  logic                    bus_ack_i,
  // Core control
  output logic [CORE_COUNT-1:0]   core_stall_o,
  input  logic [CORE_COUNT-1:0]   core_bp_i
);

  ////////////////////////////////////////
  // Chain and select state
  ////////////////////////////////////////

  dbg_word_u                chain_q;
  logic [MODULE_ID_LEN-1:0] module_id_q;
  logic [MODULE_COUNT-1:0]  module_sel;
  logic [MODULE_COUNT-1:0]  module_tdo;
  dbg_tap_t                 tap;
  logic                     tdo_bus;
  logic                     tdo_cpu;
  logic                     bus_inhibit;

  // Strobes only count while the debug instruction is loaded
  assign tap = '{
    capture_dr: capture_dr_i & debug_select_i,
    shift_dr:   shift_dr_i & debug_select_i,
    update_dr:  update_dr_i & debug_select_i,
    tdi:        tdi_i
  };

  // Main chain fills from the top so the word arrives LSB first
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      chain_q <= '0;
    end else if (tap.shift_dr) begin
      chain_q <= {tdi_i, chain_q[DATAREG_LEN-1:1]};
    end
  end

  // Module ID latch
  // held while a bus access is pending
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      module_id_q <= MODULE_BUS;
    end else if (tap.update_dr && chain_q.sel.select_cmd && !bus_inhibit) begin
      module_id_q <= chain_q.sel.module_id;
    end
  end

  // One-hot module select
  always_comb begin
    module_sel              = '0;
    module_sel[module_id_q] = 1'b1;
  end

  ////////////////////////////////////////
  // Debug modules
  ////////////////////////////////////////

  dbg_bus_module u_bus (
    .tck_i         (tck_i),
    .tlr_i         (tlr_i),
    .tap_i         (tap),
    .chain_word_i  (chain_q),
    .select_i      (module_sel[MODULE_BUS]),
    .module_tdo_o  (tdo_bus),
    .bus_inhibit_o (bus_inhibit),
    .bus_req_o     (bus_req_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_ack_i     (bus_ack_i)
  );

  dbg_cpu_module #(
    .CORE_COUNT (CORE_COUNT)
  ) u_cpu (
    .tck_i        (tck_i),
    .tlr_i        (tlr_i),
    .tap_i        (tap),
    .chain_word_i (chain_q),
    .select_i     (module_sel[MODULE_CPU]),
    .module_tdo_o (tdo_cpu),
    .core_stall_o (core_stall_o),
    .core_bp_i    (core_bp_i)
  );

  // Reserved slots drive nothing
  assign module_tdo[MODULE_BUS]        = tdo_bus;
  assign module_tdo[MODULE_CPU]        = tdo_cpu;
  assign module_tdo[MODULE_RESERVED_A] = 1'b0;
  assign module_tdo[MODULE_RESERVED_B] = 1'b0;

  // TDO mux by selected module
  assign tdo_o = |(module_sel & module_tdo);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_dbg_hub -o tb_dbg_hub
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/tb_dbg_hub)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1

//--- testbench/dbg_hub_tb.sv
`timescale 1ns/1ps

module tb_dbg_hub
  import dbg_chain_pkg::*;
  import dbg_bus_pkg::*;
();

  localparam int CORES     = 2;
  localparam int MAX_TESTS = 64;
  localparam logic [DATAREG_LEN-1:0] NOP_WORD = '0;

  logic                    tck_i;
  logic                    tlr_i;
  logic                    tdi_i;
  logic                    shift_dr_i;
  logic                    capture_dr_i;
  logic                    update_dr_i;
  logic                    debug_select_i;
  logic                    tdo_o;
  bus_req_t                bus_req;
  logic [BUS_DATA_LEN-1:0] bus_rdata_i = '0;
  logic                    bus_ack_i   = 1'b0;
  logic [CORES-1:0]        core_stall_o;
  logic [CORES-1:0]        core_bp_i;

  // Test table from the data file
  logic [8*24-1:0] test_name [MAX_TESTS];
  logic [7:0]      test_op   [MAX_TESTS];
  logic [31:0]     test_a    [MAX_TESTS];
  logic [31:0]     test_b    [MAX_TESTS];
  integer          test_c    [MAX_TESTS];

  integer      n_tests;
  integer      error_count;
  integer      resp_errors;
  integer      cycle_count = 0;
  integer      cycle_limit = 0;
  integer      ack_delay;
  integer      wait_cnt;

  // Responder state and last recorded strobe
  logic        busy;
  logic        rec_we;
  logic [7:0]  rec_addr;
  logic [31:0] rec_wdata;
  logic [31:0] mem [256];

  dbg_hub_top #(
    .CORE_COUNT (CORES)
  ) u_dut (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .tdo_o          (tdo_o),
    .bus_req_o      (bus_req),
    .bus_rdata_i    (bus_rdata_i),
    .bus_ack_i      (bus_ack_i),
    .core_stall_o   (core_stall_o),
    .core_bp_i      (core_bp_i)
  );

  initial begin
    tck_i = 1'b0;
    forever begin
      #10 tck_i = ~tck_i;
    end
  end

  ////////////////////////////////////////
  // Bus responder model
  ////////////////////////////////////////

  always @(posedge tck_i) begin
    if (tlr_i) begin
      for (int k = 0; k < 256; k++) begin
        mem[k] <= '0;
      end
      busy        <= 1'b0;
      wait_cnt    <= 0;
      resp_errors <= 0;
      bus_ack_i   <= 1'b0;
      bus_rdata_i <= '0;
    end else begin
      // Ack is a single-cycle pulse
      bus_ack_i <= 1'b0;
      if (busy && !bus_req.stb && !bus_ack_i) begin
        $display("Bus strobe dropped before the responder acknowledged");
        resp_errors <= resp_errors + 1;
        busy        <= 1'b0;
      end else if (bus_req.stb && !bus_ack_i) begin
        if (!busy) begin
          // New strobe, latch its fields
          busy      <= 1'b1;
          wait_cnt  <= ack_delay;
          rec_we    <= bus_req.we;
          rec_addr  <= bus_req.addr;
          rec_wdata <= bus_req.wdata;
        end else if (wait_cnt == 0) begin
          busy      <= 1'b0;
          bus_ack_i <= 1'b1;
          if (bus_req.we) begin
            mem[bus_req.addr] <= bus_req.wdata;
          end else begin
            bus_rdata_i <= mem[bus_req.addr];
          end
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

  // Run limit from the test count
  always @(posedge tck_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Error count: %0d checks, %0d bus model", error_count, resp_errors);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////
  // JTAG and check tasks
  ////////////////////////////////////////

  task automatic report_mismatch(input logic [8*24-1:0] name, input logic [32:0] expected,
                                 input logic [32:0] actual);
    $display("CHECK FAILED %0s: expected %h, actual %h", name, expected, actual);
    error_count = error_count + 1;
  endtask

  // Capture, 44 shifts LSB first, then Update
  task automatic shift_word(input logic [DATAREG_LEN-1:0] word,
                            output logic [BUS_RESULT_LEN-1:0] bits);
    int i;
    bits = '0;
    @(posedge tck_i);
    capture_dr_i <= 1'b1;
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
    shift_dr_i   <= 1'b1;
    tdi_i        <= word[0];
    for (i = 0; i < DATAREG_LEN; i++) begin
      // Sample mid-cycle, away from the shift edge
      @(negedge tck_i);
      if (i < BUS_RESULT_LEN) begin
        bits[i] = tdo_o;
      end
      @(posedge tck_i);
      if (i < DATAREG_LEN - 1) begin
        tdi_i <= word[i+1];
      end else begin
        shift_dr_i  <= 1'b0;
        update_dr_i <= 1'b1;
      end
    end
    @(posedge tck_i);
    update_dr_i <= 1'b0;
  endtask

  // Wait for the falling strobe
  task automatic wait_access_end(input logic [8*24-1:0] name, input logic check_rise);
    int n;
    n = 0;
    @(negedge tck_i);
    if (check_rise && bus_req.stb !== 1'b1) begin
      $display("%0s: bus strobe did not rise after the command", name);
      error_count = error_count + 1;
    end
    while (bus_req.stb === 1'b1 && n < 200) begin
      @(negedge tck_i);
      n++;
    end
    if (n >= 200) begin
      $display("%0s: bus access never completed", name);
      error_count = error_count + 1;
    end
  endtask

  // Shift out the bus result, done in bit 0
  task automatic check_read(input int t, input logic exp_done);
    logic [BUS_RESULT_LEN-1:0] bits;
    shift_word(NOP_WORD, bits);
    if (bits[0] !== exp_done) begin
      report_mismatch(test_name[t], {32'b0, exp_done}, {32'b0, bits[0]});
    end
    if (exp_done && bits[32:1] !== test_b[t]) begin
      report_mismatch(test_name[t], {1'b0, test_b[t]}, {1'b0, bits[32:1]});
    end
  endtask

  // Stall lines, then a status read
  task automatic check_status(input int t, input logic [CORES-1:0] exp_stall);
    logic [BUS_RESULT_LEN-1:0] bits;
    @(negedge tck_i);
    if (core_stall_o !== exp_stall) begin
      report_mismatch(test_name[t], {{(33-CORES){1'b0}}, exp_stall},
                      {{(33-CORES){1'b0}}, core_stall_o});
    end
    shift_word({1'b0, OP_CPU_STATUS, 8'h00, 32'h0}, bits);
    // Breakpoints already dropped, upper half stays 0
    if (bits[31:0] !== {{(32-CORES){1'b0}}, exp_stall}) begin
      report_mismatch(test_name[t], {{(33-CORES){1'b0}}, exp_stall}, {1'b0, bits[31:0]});
    end
  endtask

  task automatic load_tests();
    integer           fd;
    integer           code;
    logic [8*24-1:0]  name_buf;
    logic [7:0]       op_buf;
    logic [31:0]      a_buf;
    logic [31:0]      b_buf;
    integer           c_buf;
    logic [8*120-1:0] rest;
    n_tests = 0;
    fd = $fopen("testbench/dbg_hub_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file");
      error_count = error_count + 1;
    end else begin
      code = $fscanf(fd, "%s", name_buf);
      while (code == 1 && n_tests < MAX_TESTS) begin
        // Lone # token starts a comment line
        if (name_buf == {{23{8'h00}}, "#"}) begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %d", op_buf, a_buf, b_buf, c_buf);
          if (code != 4) begin
            $display("Malformed line in the test file after %0s", name_buf);
            error_count = error_count + 1;
          end else begin
            test_name[n_tests] = name_buf;
            test_op[n_tests]   = op_buf;
            test_a[n_tests]    = a_buf;
            test_b[n_tests]    = b_buf;
            test_c[n_tests]    = c_buf;
            n_tests            = n_tests + 1;
          end
        end
        code = $fscanf(fd, "%s", name_buf);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int t);
    logic [BUS_RESULT_LEN-1:0] bits;
    // Negative delay column picks a random 0 to 3
    ack_delay = (test_c[t] < 0) ? $urandom % 4 : test_c[t];
    case (test_op[t])
      "R": begin
        @(negedge tck_i);
        if (tdo_o !== 1'b0 || core_stall_o !== '0 || bus_req.stb !== 1'b0) begin
          report_mismatch(test_name[t], 33'h0,
                          {30'b0, bus_req.stb, core_stall_o != '0, tdo_o});
        end
      end
      "S": begin
        // Ones in the unused field leave bit 0 set in the module shifting it
        shift_word({1'b1, test_a[t][1:0], {41{1'b1}}}, bits);
      end
      "Z": begin
        shift_word(NOP_WORD, bits);
        if (bits !== '0) begin
          report_mismatch(test_name[t], 33'h0, bits);
        end
      end
      "W": begin
        shift_word({1'b0, OP_BUS_WRITE, test_a[t][7:0], test_b[t]}, bits);
        wait_access_end(test_name[t], 1'b1);
        if (rec_we !== 1'b1 || rec_addr !== test_a[t][7:0]) begin
          report_mismatch(test_name[t], {24'b0, 1'b1, test_a[t][7:0]},
                          {24'b0, rec_we, rec_addr});
        end
        if (rec_wdata !== test_b[t]) begin
          report_mismatch(test_name[t], {1'b0, test_b[t]}, {1'b0, rec_wdata});
        end
      end
      "D": begin
        shift_word({1'b0, OP_BUS_READ, test_a[t][7:0], 32'h0}, bits);
        wait_access_end(test_name[t], 1'b1);
        check_read(t, 1'b1);
      end
      "I": begin
        shift_word({1'b0, OP_BUS_READ, test_a[t][7:0], 32'h0}, bits);
        // CPU select arrives while the strobe is still high
        shift_word({1'b1, MODULE_CPU, 41'b0}, bits);
        check_read(t, 1'b0);
        wait_access_end(test_name[t], 1'b0);
        check_read(t, 1'b1);
      end
      "C": begin
        shift_word({1'b0, OP_CPU_STALL_SET, 8'h00, test_a[t]}, bits);
        check_status(t, test_a[t][CORES-1:0]);
      end
      "B": begin
        // One-cycle breakpoint pulse
        @(posedge tck_i);
        core_bp_i <= {{(CORES-1){1'b0}}, 1'b1} << test_a[t];
        @(posedge tck_i);
        core_bp_i <= '0;
        @(posedge tck_i);
        check_status(t, test_b[t][CORES-1:0]);
      end
      default: begin
        $display("Unknown operation in test %0s", test_name[t]);
        error_count = error_count + 1;
      end
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(89152));
    tlr_i          <= 1'b1;
    tdi_i          <= 1'b0;
    shift_dr_i     <= 1'b0;
    capture_dr_i   <= 1'b0;
    update_dr_i    <= 1'b0;
    debug_select_i <= 1'b0;
    core_bp_i      <= '0;
    ack_delay      = 0;
    error_count    = 0;
    load_tests();
    if (n_tests == 0) begin
      $display("No tests were loaded");
      error_count = error_count + 1;
    end
    cycle_limit = n_tests * 150 + 50;
    repeat (8) @(posedge tck_i);
    tlr_i          <= 1'b0;
    debug_select_i <= 1'b1;
    @(posedge tck_i);
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    repeat (2) @(posedge tck_i);
    $display("Error count: %0d checks, %0d bus model", error_count, resp_errors);
    if (error_count + resp_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- testbench/dbg_hub_tests.txt
# name op a b c : hex a and b, decimal c (ack delay, -1 picks random)
# R reset, S select id a, Z zero shift-out, W write a b, D read a expect b, I read a under inhibit
# C stall mask a, B breakpoint on core a expecting stall mask b
reset_state      R 0  00000000 0
sel_reserved_a   S 2  00000000 0
reserved_zero_a  Z 0  00000000 0
sel_reserved_b   S 3  00000000 0
reserved_zero_b  Z 0  00000000 0
sel_bus          S 0  00000000 0
read_unwritten   D 33 00000000 -1
write_10         W 10 cafef00d -1
write_7f         W 7f 12345678 3
write_ff         W ff a5a55a5a 0
read_10          D 10 cafef00d -1
read_7f          D 7f 12345678 2
write_10_again   W 10 0badbeef -1
read_10_again    D 10 0badbeef -1
read_ff          D ff a5a55a5a 0
inhibit_sel      I 7f 12345678 60
read_after       D 10 0badbeef 1
write_00         W 00 ffffffff -1
read_00          D 00 ffffffff -1
sel_cpu          S 1  00000000 0
stall_both       C 3  00000000 0
stall_core0      C 1  00000000 0
stall_none       C 0  00000000 0
bp_core1         B 1  00000002 0
stall_clear      C 0  00000000 0
bp_core0         B 0  00000001 0
stall_core1      C 2  00000000 0
bp_core0_add     B 0  00000003 0
stall_final      C 0  00000000 0
sel_bus_end      S 0  00000000 0
